//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_top
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- files.f
+incdir+src
src/isa_pkg.sv
src/ctrl_pkg.sv
src/decoder.sv
src/reg_file.sv
src/alu.sv
src/pc_unit.sv
src/lsu.sv
src/core_top.sv
tests/core_checker.sv
tests/tb_top.sv

//--- src/alu.sv
// combinational alu of the subset; no subtract or compare, shift amount is the low five bits
`timescale 1ns/1ps

module alu import isa_pkg::*; import ctrl_pkg::*; (
    input  ctrl_t ctrl,
    input  word_t pc,
    input  word_t rs1_data,
    input  word_t rs2_data,
    input  word_t imm,
    output word_t result
);

    word_t      op_a;
    word_t      op_b;
    word_t      rs1_val;
    word_t      rs2_val;
    logic [4:0] shamt;

    // unread registers count as zero, lui relies on this
    assign rs1_val = ctrl.rs_ren[0] ? rs1_data : '0;
    assign rs2_val = ctrl.rs_ren[1] ? rs2_data : '0;

    always_comb begin
        case (ctrl.alu_src)
            src_pc_imm:  begin op_a = pc;      op_b = imm;     end
            src_rs1_rs2: begin op_a = rs1_val; op_b = rs2_val; end
            src_rs1_imm: begin op_a = rs1_val; op_b = imm;     end
            default:     begin op_a = '0;      op_b = '0;      end
        endcase
    end

    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            alu_add: result = op_a + op_b;
            alu_and: result = op_a & op_b;
            alu_or:  result = op_a | op_b;
            alu_xor: result = op_a ^ op_b;
            alu_shift: begin
                // right shifts fill with sign unless unsigned
                if (!ctrl.shift_right) begin
                    result = op_a << shamt;
                end else if (ctrl.unsigned_en) begin
                    result = op_a >> shamt;
                end else begin
                    result = word_t'($signed(op_a) >>> shamt);
                end
            end
            // return address
            alu_link: result = pc + 32'd4;
            default:  result = '0;
        endcase
    end

endmodule

//--- src/core_macros.svh
// core-wide constants; reset vector and memory width assume a 32-bit bus of 4 byte lanes
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// pc value while and after reset
`define CORE_RESET_VECTOR 32'h80000000

// architectural register count, x0 included
`define CORE_NUM_REGS 32

// byte strobes per data word
`define CORE_WSTRB_W 4

`endif

//--- src/core_top.sv
// single-cycle rv32 subset core; memories answer combinationally, no stalls or back-pressure
`timescale 1ns/1ps

module core_top import isa_pkg::*; import ctrl_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    output word_t    imem_addr,
    input  word_t    imem_rdata,
    output word_t    dmem_addr,
    output word_t    dmem_wdata,
    output wstrb_t   dmem_wstrb,
    input  word_t    dmem_rdata,
    output logic     wb_en,
    output reg_idx_t wb_rd,
    output word_t    wb_data
);

    word_t    pc;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;
    ctrl_t    ctrl;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    alu_result;

    // fetch at the current pc
    assign imem_addr = pc;

    // writeback trace matches the register file write port
    assign wb_en = ctrl.reg_wen;
    assign wb_rd = rd;

    decoder u_decoder (
        .inst (imem_rdata),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd),
        .imm  (imm),
        .ctrl (ctrl)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .waddr  (rd),
        .wen    (wb_en),
        .wdata  (wb_data),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    alu u_alu (
        .ctrl     (ctrl),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .result   (alu_result)
    );

    // load and store address is the alu sum
    lsu u_lsu (
        .ctrl       (ctrl),
        .addr       (alu_result),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .dmem_rdata (dmem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wstrb (dmem_wstrb),
        .wb_data    (wb_data)
    );

    pc_unit u_pc_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .pc_sel   (ctrl.pc_sel),
        .imm      (imm),
        .rs1_data (rs1_data),
        .pc       (pc)
    );

endmodule

//--- src/ctrl_pkg.sv
// control word types; encodings mirror the option word of the earlier core, no sub or branch ops
`include "core_macros.svh"

package ctrl_pkg;

    // alu operand pair
    typedef enum logic [1:0] {
        src_none    = 2'b00,
        src_pc_imm  = 2'b01,
        src_rs1_rs2 = 2'b10,
        src_rs1_imm = 2'b11
    } alu_src_e;

    // alu operation, link is pc + 4
    typedef enum logic [2:0] {
        alu_none  = 3'b000,
        alu_add   = 3'b001,
        alu_and   = 3'b010,
        alu_or    = 3'b011,
        alu_xor   = 3'b100,
        alu_shift = 3'b101,
        alu_link  = 3'b110
    } alu_op_e;

    // next pc source
    typedef enum logic [1:0] {
        pc_none    = 2'b00,
        pc_seq     = 2'b01,
        pc_pc_imm  = 2'b10,
        pc_rs1_imm = 2'b11
    } pc_sel_e;

    // memory access, bit 2 marks a load
    typedef enum logic [2:0] {
        mem_none = 3'b000,
        mem_sb   = 3'b001,
        mem_sh   = 3'b010,
        mem_sw   = 3'b011,
        mem_lb   = 3'b101,
        mem_lh   = 3'b110,
        mem_lw   = 3'b111
    } mem_op_e;

    // decoded control word
    typedef struct packed {
        logic     reg_wen;
        // [1] rs2, [0] rs1
        logic [1:0] rs_ren;
        alu_src_e alu_src;
        alu_op_e  alu_op;
        pc_sel_e  pc_sel;
        mem_op_e  mem_op;
        logic     shift_right;
        // zero-extend on loads, logical fill on right shifts
        logic     unsigned_en;
    } ctrl_t;

    // byte strobes of one data word
    typedef logic [`CORE_WSTRB_W-1:0] wstrb_t;

endpackage

//--- src/decoder.sv
// rv32 subset decode; sub, slt and every other encoding come out as a pc + 4 no-op
`timescale 1ns/1ps

module decoder import isa_pkg::*; import ctrl_pkg::*; (
    input  word_t    inst,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd,
    output word_t    imm,
    output ctrl_t    ctrl
);

    // sequential no-op, all enables low
    localparam ctrl_t ctrl_nop = '{
        reg_wen: 1'b0, rs_ren: 2'b00, alu_src: src_none, alu_op: alu_none,
        pc_sel: pc_seq, mem_op: mem_none, shift_right: 1'b0, unsigned_en: 1'b0
    };

    opcode_e    opcode;
    funct3_t    funct3;
    logic [6:0] funct7;
    word_t      i_imm;
    word_t      s_imm;
    word_t      u_imm;
    word_t      j_imm;
    word_t      shamt;
    alu_op_e    arith_op;
    logic       shift_f7_ok;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    // immediate formats
    assign i_imm = {{20{inst[31]}}, inst[31:20]};
    assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign u_imm = {inst[31:12], 12'b0};
    assign j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign shamt = {27'b0, inst[24:20]};

    // funct7 is zero except for the arithmetic right shift
    assign shift_f7_ok = (funct7 == 7'b0000000) ||
                         (funct7 == 7'b0100000 && funct3 == f3_sr);

    // alu op shared by op and op_imm
    always_comb begin
        case (funct3)
            f3_add:        arith_op = alu_add;
            f3_and:        arith_op = alu_and;
            f3_or:         arith_op = alu_or;
            f3_xor:        arith_op = alu_xor;
            f3_sll, f3_sr: arith_op = alu_shift;
            default:       arith_op = alu_none;
        endcase
    end

    always_comb begin
        ctrl = ctrl_nop;
        imm  = '0;
        case (opcode)
            opc_lui: begin
                // rs1 read disabled, so the sum is the immediate alone
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = src_rs1_imm;
                ctrl.alu_op  = alu_add;
                imm          = u_imm;
            end
            opc_auipc: begin
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = src_pc_imm;
                ctrl.alu_op  = alu_add;
                imm          = u_imm;
            end
            opc_jal: begin
                ctrl.reg_wen = 1'b1;
                ctrl.alu_op  = alu_link;
                ctrl.pc_sel  = pc_pc_imm;
                imm          = j_imm;
            end
            opc_jalr: begin
                if (funct3 == 3'b000) begin
                    ctrl.reg_wen = 1'b1;
                    ctrl.rs_ren  = 2'b01;
                    ctrl.alu_op  = alu_link;
                    ctrl.pc_sel  = pc_rs1_imm;
                    imm          = i_imm;
                end
            end
            opc_op_imm, opc_op: begin
                // immediate shifts take the same funct7 rule as register shifts
                if (arith_op != alu_none && (opcode == opc_op || arith_op != alu_shift ||
                                             shift_f7_ok) &&
                    (opcode == opc_op_imm || shift_f7_ok)) begin
                    ctrl.reg_wen     = 1'b1;
                    ctrl.rs_ren      = (opcode == opc_op) ? 2'b11 : 2'b01;
                    ctrl.alu_src     = (opcode == opc_op) ? src_rs1_rs2 : src_rs1_imm;
                    ctrl.alu_op      = arith_op;
                    ctrl.shift_right = (funct3 == f3_sr);
                    ctrl.unsigned_en = (funct3 == f3_sr) && !funct7[5];
                    imm              = (arith_op == alu_shift) ? shamt : i_imm;
                end
            end
            opc_load: begin
                // lb lh lw lbu lhu, bit 2 of funct3 is zero-extension
                if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
                    ctrl.reg_wen     = 1'b1;
                    ctrl.rs_ren      = 2'b01;
                    ctrl.alu_src     = src_rs1_imm;
                    ctrl.alu_op      = alu_add;
                    ctrl.mem_op      = mem_op_e'({1'b1, funct3[1:0] + 2'b01});
                    ctrl.unsigned_en = funct3[2];
                    imm              = i_imm;
                end
            end
            opc_store: begin
                if (funct3[2] == 1'b0 && funct3[1:0] != 2'b11) begin
                    ctrl.rs_ren  = 2'b11;
                    ctrl.alu_src = src_rs1_imm;
                    ctrl.alu_op  = alu_add;
                    ctrl.mem_op  = mem_op_e'({1'b0, funct3[1:0] + 2'b01});
                    imm          = s_imm;
                end
            end
            default: begin
                ctrl = ctrl_nop;
            end
        endcase
    end

endmodule

//--- src/isa_pkg.sv
// instruction-level types for the rv32 subset; only the eight supported major opcodes are named
package isa_pkg;

    // data and address word
    typedef logic [31:0] word_t;

    // register index
    typedef logic [4:0] reg_idx_t;

    // minor opcode field
    typedef logic [2:0] funct3_t;

    // major opcodes of the supported groups
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011
    } opcode_e;

    // arithmetic funct3 values, shared by op and op_imm
    localparam funct3_t f3_add = 3'b000;
    localparam funct3_t f3_sll = 3'b001;
    localparam funct3_t f3_xor = 3'b100;
    localparam funct3_t f3_sr  = 3'b101;
    localparam funct3_t f3_or  = 3'b110;
    localparam funct3_t f3_and = 3'b111;

endpackage

//--- src/lsu.sv
// load/store lanes; accesses are assumed naturally aligned, misaligned ones are not detected
`timescale 1ns/1ps

module lsu import isa_pkg::*; import ctrl_pkg::*; (
    input  ctrl_t  ctrl,
    input  word_t  addr,
    input  word_t  rs2_data,
    input  word_t  alu_result,
    input  word_t  dmem_rdata,
    output word_t  dmem_addr,
    output word_t  dmem_wdata,
    output wstrb_t dmem_wstrb,
    output word_t  wb_data
);

    logic [1:0] lane;
    logic [4:0] lane_shift;
    word_t      load_word;
    logic       sext;

    // word address, byte lane from the low bits
    assign dmem_addr  = {addr[31:2], 2'b00};
    assign lane       = addr[1:0];
    assign lane_shift = {lane, 3'b000};

    // store strobes and data moved into the lane
    always_comb begin
        dmem_wstrb = '0;
        dmem_wdata = '0;
        case (ctrl.mem_op)
            mem_sb: begin
                dmem_wstrb = wstrb_t'(4'b0001 << lane);
                dmem_wdata = rs2_data << lane_shift;
            end
            mem_sh: begin
                dmem_wstrb = wstrb_t'(4'b0011 << lane);
                dmem_wdata = rs2_data << lane_shift;
            end
            mem_sw: begin
                dmem_wstrb = '1;
                dmem_wdata = rs2_data;
            end
            default: ;
        endcase
    end

    // addressed byte or half moved down to bit 0
    assign load_word = dmem_rdata >> lane_shift;
    assign sext      = !ctrl.unsigned_en;

    always_comb begin
        case (ctrl.mem_op)
            mem_lb:  wb_data = {{24{sext & load_word[7]}}, load_word[7:0]};
            mem_lh:  wb_data = {{16{sext & load_word[15]}}, load_word[15:0]};
            mem_lw:  wb_data = dmem_rdata;
            default: wb_data = alu_result;
        endcase
    end

endmodule

//--- src/pc_unit.sv
// program counter; no traps or alignment checks, jalr target has bit 0 cleared only
`timescale 1ns/1ps
`include "core_macros.svh"

module pc_unit import isa_pkg::*; import ctrl_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  pc_sel_e pc_sel,
    input  word_t   imm,
    input  word_t   rs1_data,
    output word_t   pc
);

    word_t next_pc;
    word_t rs1_target;

    assign rs1_target = rs1_data + imm;

    // none also falls through to pc + 4
    always_comb begin
        case (pc_sel)
            pc_pc_imm:  next_pc = pc + imm;
            pc_rs1_imm: next_pc = {rs1_target[31:1], 1'b0};
            default:    next_pc = pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `CORE_RESET_VECTOR;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

//--- src/reg_file.sv
// integer register file; reads are combinational, writes land at the rising edge, no reset
`timescale 1ns/1ps
`include "core_macros.svh"

module reg_file import isa_pkg::*; (
    input  logic     clk,
    input  reg_idx_t waddr,
    input  logic     wen,
    input  word_t    wdata,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t regs [`CORE_NUM_REGS];

    // x0 never written
    always_ff @(posedge clk) begin
        if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero whatever the array holds
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- tests/core_checker.sv
// reference model of the rv32 subset; register state carries over between tests like the core's
`timescale 1ns/1ps
`include "core_macros.svh"

module core_checker import isa_pkg::*; import ctrl_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input word_t    imem_addr,
    input word_t    dmem_addr,
    input word_t    dmem_wdata,
    input wstrb_t   dmem_wstrb,
    input logic     wb_en,
    input reg_idx_t wb_rd,
    input word_t    wb_data
);

    // expected port values of one cycle
    typedef struct packed {
        logic     wen;
        reg_idx_t rd;
        word_t    data;
        wstrb_t   strb;
        word_t    wdata;
    } resp_t;

    word_t prog [1024];
    word_t mem [1024];
    word_t regs [`CORE_NUM_REGS];
    word_t pc;
    int    errors = 0;

    // copies of the test's memories
    task automatic load_word(input int idx, input word_t iw, input word_t dw);
        prog[idx] = iw;
        mem[idx]  = dw;
    endtask

    // hands back the count of the finished test and clears it
    function automatic int take_errors();
        int n;
        n      = errors;
        errors = 0;
        return n;
    endfunction

    task automatic fail_value(input string field, input word_t exp, input word_t got);
        $display("Fail at time %0t: %s expected %h got %h", $time, field, exp, got);
        errors++;
    endtask

    task automatic step();
        word_t      inst;
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        word_t      a;
        word_t      b;
        word_t      i_imm;
        word_t      s_imm;
        word_t      addr;
        word_t      w;
        word_t      npc;
        logic [4:0] sh;
        logic       ok;
        logic       acc;
        resp_t      e;
        inst  = prog[pc[11:2]];
        opc   = inst[6:0];
        f3    = inst[14:12];
        f7    = inst[31:25];
        a     = (inst[19:15] == 5'd0) ? 32'd0 : regs[inst[19:15]];
        b     = (inst[24:20] == 5'd0) ? 32'd0 : regs[inst[24:20]];
        i_imm = {{20{inst[31]}}, inst[31:20]};
        s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        e     = '0;
        e.rd  = inst[11:7];
        npc   = pc + 32'd4;
        addr  = 32'd0;
        acc   = 1'b0;
        case (opc)
            7'h37: begin
                e.wen  = 1'b1;
                e.data = {inst[31:12], 12'd0};
            end
            7'h17: begin
                e.wen  = 1'b1;
                e.data = pc + {inst[31:12], 12'd0};
            end
            7'h6f: begin
                e.wen  = 1'b1;
                e.data = pc + 32'd4;
                npc    = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            7'h67: begin
                if (f3 == 3'd0) begin
                    e.wen  = 1'b1;
                    e.data = pc + 32'd4;
                    npc    = (a + i_imm) & ~32'd1;
                end
            end
            7'h13, 7'h33: begin
                // second operand is rs2 for op, immediate for op_imm
                if (opc == 7'h33) begin
                    w = b;
                end else begin
                    w = i_imm;
                end
                sh = w[4:0];
                case (f3)
                    3'd0, 3'd4, 3'd6, 3'd7: ok = (opc == 7'h13) || (f7 == 7'd0);
                    3'd1:                   ok = (f7 == 7'd0);
                    3'd5:                   ok = (f7 == 7'd0) || (f7 == 7'h20);
                    default:                ok = 1'b0;
                endcase
                e.wen = ok;
                case (f3)
                    3'd0:    e.data = a + w;
                    3'd4:    e.data = a ^ w;
                    3'd6:    e.data = a | w;
                    3'd7:    e.data = a & w;
                    3'd1:    e.data = a << sh;
                    3'd5:    e.data = f7[5] ? word_t'($signed(a) >>> sh) : a >> sh;
                    default: e.data = 32'd0;
                endcase
            end
            7'h03: begin
                addr  = a + i_imm;
                w     = mem[addr[11:2]] >> {addr[1:0], 3'b000};
                e.wen = 1'b1;
                case (f3)
                    3'd0:    e.data = {{24{w[7]}}, w[7:0]};
                    3'd1:    e.data = {{16{w[15]}}, w[15:0]};
                    3'd2:    e.data = w;
                    3'd4:    e.data = {24'd0, w[7:0]};
                    3'd5:    e.data = {16'd0, w[15:0]};
                    default: e.wen = 1'b0;
                endcase
                // word address only defined for a real load
                acc = e.wen;
            end
            7'h23: begin
                addr    = a + s_imm;
                e.wdata = b << {addr[1:0], 3'b000};
                case (f3)
                    3'd0:    e.strb = 4'b0001 << addr[1:0];
                    3'd1:    e.strb = 4'b0011 << addr[1:0];
                    3'd2:    e.strb = 4'b1111;
                    default: e.strb = 4'b0000;
                endcase
                acc = (e.strb != 4'b0000);
            end
            default: ;
        endcase
        if (!e.wen) begin
            e.data = 32'd0;
        end

        // compare the cycle, pc first
        if (imem_addr !== pc) begin
            $display("Fail at time %0t: pc left the expected instruction stream", $time);
            errors++;
        end else begin
            if (wb_en !== e.wen) fail_value("wb_en", 32'(e.wen), 32'(wb_en));
            if (e.wen && wb_rd !== e.rd) fail_value("wb_rd", 32'(e.rd), 32'(wb_rd));
            if (e.wen && wb_data !== e.data) fail_value("wb_data", e.data, wb_data);
            if (dmem_wstrb !== e.strb) fail_value("dmem_wstrb", 32'(e.strb), 32'(dmem_wstrb));
            if (acc && dmem_addr !== (addr & ~32'd3)) begin
                fail_value("dmem_addr", addr & ~32'd3, dmem_addr);
            end
            for (int k = 0; k < 4; k++) begin
                if (e.strb[k] && dmem_wdata[8*k +: 8] !== e.wdata[8*k +: 8]) begin
                    fail_value("dmem_wdata", e.wdata, dmem_wdata);
                end
            end
        end

        // advance the model
        if (e.wen && e.rd != 5'd0) begin
            regs[e.rd] = e.data;
        end
        for (int k = 0; k < 4; k++) begin
            if (e.strb[k]) begin
                mem[addr[11:2]][8*k +: 8] = e.wdata[8*k +: 8];
            end
        end
        pc = npc;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            // pc pinned to the reset vector
            if (imem_addr !== `CORE_RESET_VECTOR) begin
                fail_value("imem_addr in reset", `CORE_RESET_VECTOR, imem_addr);
            end
            pc = `CORE_RESET_VECTOR;
        end else begin
            step();
        end
    end

endmodule

//--- tests/tb_top.sv
// testbench of core_top; random programs of 66 instructions, memories of 4 KB by addr[11:2]
`timescale 1ns/1ps
`include "core_macros.svh"

module tb_top import isa_pkg::*; import ctrl_pkg::*; ();

    localparam int    prog_len  = 66;
    localparam int    num_tests = 7;
    localparam word_t nop       = 32'h00000013;
    // two times the nominal run length
    localparam longint limit_ns = longint'(num_tests) * (prog_len + 8) * 10 * 2;

    logic     clk = 1'b0;
    logic     rst_n = 1'b1;
    word_t    imem_addr;
    word_t    imem_rdata;
    word_t    dmem_addr;
    word_t    dmem_wdata;
    wstrb_t   dmem_wstrb;
    word_t    dmem_rdata;
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;
    word_t    imem [1024];
    word_t    dmem [1024];
    int       passed = 0;
    int       failed = 0;

    always #5 clk = ~clk;

    // memories answer in the same cycle
    assign imem_rdata = imem[imem_addr[11:2]];
    assign dmem_rdata = dmem[dmem_addr[11:2]];

    always @(posedge clk) begin
        for (int k = 0; k < 4; k++) begin
            if (dmem_wstrb[k]) begin
                dmem[dmem_addr[11:2]][8*k +: 8] <= dmem_wdata[8*k +: 8];
            end
        end
    end

    core_top core_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wstrb (dmem_wstrb),
        .dmem_rdata (dmem_rdata),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    core_checker core_checker_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wstrb (dmem_wstrb),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    // instruction formats
    function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input funct3_t f3, input reg_idx_t rd, input opcode_e opc);
        return {imm, rs1, f3, rd, 7'(opc)};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input funct3_t f3, input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, 7'(opc_op)};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                    input funct3_t f3);
        return {imm[11:5], rs2, 5'd31, f3, imm[4:0], 7'(opc_store)};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
                                    input opcode_e opc);
        return {imm, rd, 7'(opc)};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'(opc_jal)};
    endfunction

    // loads every register with a full random word
    task automatic build_init_program();
        for (int r = 1; r < 32; r++) begin
            imem[2*r-2] = enc_u(20'($urandom), 5'(r), opc_lui);
            imem[2*r-1] = enc_i(12'($urandom), 5'(r), 3'd0, 5'(r), opc_op_imm);
        end
    endtask

    task automatic build_random_program();
        reg_idx_t   rd;
        reg_idx_t   ra;
        reg_idx_t   rb;
        funct3_t    f3;
        logic [6:0] f7;
        int         t;
        // data base in x31, pc of index 1 in x30
        imem[0] = enc_u(20'h80001, 5'd31, opc_lui);
        imem[1] = enc_u(20'h0, 5'd30, opc_auipc);
        for (int i = 2; i < prog_len; i++) begin
            rd = 5'($urandom % 30);
            ra = 5'($urandom);
            rb = 5'($urandom);
            f3 = 3'($urandom);
            case ($urandom % 16)
                0: imem[i] = enc_u(20'($urandom), rd, opc_lui);
                1: imem[i] = enc_u(20'($urandom), rd, opc_auipc);
                2: imem[i] = enc_j(21'(4 * (1 + $urandom % 4)), rd);
                3: begin
                    // forward target, bit 0 sometimes set
                    t = i + 1 + int'($urandom % 4);
                    imem[i] = enc_i(12'(4 * t - 4 + $urandom % 2), 5'd30, 3'd0, rd, opc_jalr);
                end
                6: begin
                    f3 = ($urandom % 2) ? 3'd5 : 3'd1;
                    f7 = (f3 == 3'd5 && $urandom % 2) ? 7'h20 : 7'h00;
                    imem[i] = enc_i({f7, 5'($urandom)}, ra, f3, rd, opc_op_imm);
                end
                7, 8: begin
                    if (f3 == 3'd2 || f3 == 3'd3) f3 = 3'd0;
                    f7 = (f3 == 3'd5 && $urandom % 2) ? 7'h20 : 7'h00;
                    imem[i] = enc_r(f7, rb, ra, f3, rd);
                end
                9, 10: begin
                    f3 = 3'(($urandom % 3) + (($urandom % 2) ? 4 : 0));
                    if (f3 == 3'd6) f3 = 3'd2;
                    imem[i] = enc_i(12'((($urandom % 256) >> f3[1:0]) << f3[1:0]),
                                    5'd31, f3, rd, opc_load);
                end
                11, 12: begin
                    f3 = 3'($urandom % 3);
                    imem[i] = enc_s(12'((($urandom % 256) >> f3[1:0]) << f3[1:0]), rb, f3);
                end
                13: begin
                    // sub, slt, beq, load funct3 3, all zero
                    case ($urandom % 5)
                        0: imem[i] = enc_r(7'h20, rb, ra, 3'd0, rd);
                        1: imem[i] = enc_r(7'h00, rb, ra, 3'd2, rd);
                        2: imem[i] = {7'd0, rb, ra, 3'd0, 5'd8, 7'h63};
                        3: imem[i] = enc_i(12'd0, 5'd31, 3'd3, rd, opc_load);
                        default: imem[i] = 32'd0;
                    endcase
                end
                default: begin
                    if (f3 == 3'd1 || f3 == 3'd5 || f3 == 3'd2 || f3 == 3'd3) f3 = 3'd0;
                    imem[i] = enc_i(12'($urandom), ra, f3, rd, opc_op_imm);
                end
            endcase
        end
    endtask

    // entered one step after a rising edge
    task automatic run_test(input int num, input bit init);
        int errs;
        rst_n = 1'b0;
        for (int k = 0; k < 1024; k++) begin
            imem[k] = nop;
            dmem[k] = $urandom;
        end
        if (init) begin
            build_init_program();
        end else begin
            build_random_program();
        end
        for (int k = 0; k < 1024; k++) begin
            core_checker_i.load_word(k, imem[k], dmem[k]);
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (prog_len + 4) @(posedge clk);
        #1;
        errs = core_checker_i.take_errors();
        if (errs == 0) begin
            passed++;
        end else begin
            failed++;
        end
        $display("test %0d (%s): %0d errors", num, init ? "register init" : "random", errs);
    endtask

    initial begin
        void'($urandom(32'ha78254ba));
        // first falling edge of rst_n a step after time zero
        #1;
        run_test(0, 1'b1);
        for (int n = 1; n < num_tests; n++) begin
            run_test(n, 1'b0);
        end
        $display("tests passed %0d, failed %0d", passed, failed);
        if (failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(limit_ns);
        $display("timeout: the tests did not finish in time");
        $display("Testbench failed");
        $finish;
    end

endmodule
